// ==== sim.f ====
vec_cfg_pkg.sv
store_bus_pkg.sv
store_sequencer.sv
lane_pack.sv
lane_bank.sv
elem_extract.sv
store_unit_top.sv
store_unit_properties.sv
tb_store_unit.sv

// ==== Bender.yml ====
package:
  name: store_unit

sources:
  # Packages, then the design bottom up
  - vec_cfg_pkg.sv
  - store_bus_pkg.sv
  - store_sequencer.sv
  - lane_pack.sv
  - lane_bank.sv
  - elem_extract.sv
  - store_unit_top.sv

  # Testbench and bound assertions
  - target: simulation
    files:
      - store_unit_properties.sv
      - tb_store_unit.sv

// ==== tb_store_unit.sv ====
// Testbench for the store unit
// Test table, stimulus loop, credit return, scoreboard and watchdog
`timescale 1ns/1ps

module tb_store_unit
  import vec_cfg_pkg::*;
  import store_bus_pkg::*;
;

  localparam int LANES   = 4;
  localparam int CREDITS = 4;
  localparam int NROWS   = 7;

  typedef struct {
    string        name;
    sew_e         sew;
    stride_mode_e mode;
    logic [31:0]  base;
    logic [31:0]  stride;
    int           batches;
    int           delay;    // Cycles from a beat to its credit return
  } row_t;

  logic                   clk;
  logic                   rstn;
  logic                   cfg_load_i;
  store_cfg_t             cfg_i;
  logic                   lane_valid_i;
  logic [LANES-1:0][31:0] lane_elem_i;
  logic                   credit_return_i;
  logic                   fill_ready_o;
  logic                   beat_valid_o;
  beat_t                  beat_o;
  logic                   done_o;

  row_t  rows [NROWS];
  beat_t exp_q [$];       // Expected beats in element order
  int    due_q [$];       // Cycles at which credits go back
  int    ncycle     = 0;
  int    errors     = 0;
  int    checks     = 0;
  int    unreturned = 0;
  int    cur_delay  = 0;
  string cur_name   = "reset";

  store_unit_top store_unit_i (
    .clk             (clk),
    .rstn            (rstn),
    .cfg_load_i      (cfg_load_i),
    .cfg_i           (cfg_i),
    .lane_valid_i    (lane_valid_i),
    .lane_elem_i     (lane_elem_i),
    .credit_return_i (credit_return_i),
    .fill_ready_o    (fill_ready_o),
    .beat_valid_o    (beat_valid_o),
    .beat_o          (beat_o),
    .done_o          (done_o)
  );

  bind store_sequencer store_unit_properties #(
    .CREDITS (CREDITS),
    .CRED_W  (CRED_W)
  ) props_i (
    .clk          (clk),
    .rstn         (rstn),
    .credit_i     (credit_q),
    .req_valid_i  (rd_req_o.valid),
    .fill_ready_i (fill_ready_o),
    .done_i       (done_o)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  task automatic check_value(string what, logic [31:0] expected, logic [31:0] actual);
    checks++;
    if (expected !== actual) begin
      errors++;
      $display("error %s %s: expected %h, actual %h", cur_name, what, expected, actual);
    end
  endtask

  //////////////////////////////////////////////////////////////
  // Reference beat from element index and raw lane value
  //////////////////////////////////////////////////////////////
  function automatic beat_t expected_beat(row_t row, int e, logic [31:0] elem);
    beat_t       bt;
    logic [31:0] addr;
    logic [31:0] step;
    logic [31:0] val;
    logic [3:0]  mask;
    int          bytes;
    int          sh;
    bytes = 1 << int'(row.sew);
    step  = (row.mode == MODE_STRIDED) ? row.stride : 32'(bytes);
    addr  = row.base + e * step;
    val   = (bytes == 4) ? elem : elem & ((32'd1 << (8 * bytes)) - 32'd1);  // Zero-extend
    mask  = 4'((1 << bytes) - 1);
    sh    = int'(addr[1:0]);
    bt.addr   = {addr[31:2], 2'b00};
    bt.data   = (val << (8 * sh)) | (val >> (32 - 8 * sh));
    bt.strobe = (mask << sh) | (mask >> (4 - sh));
    return bt;
  endfunction

  task automatic load_table();
    rows[0] = '{"unit_sew32",        SEW_32, MODE_UNIT,    32'h0000_1000, 32'd0,  4, 1};
    rows[1] = '{"unit_sew16",        SEW_16, MODE_UNIT,    32'h0000_2000, 32'd0,  6, 0};
    rows[2] = '{"unit_sew8",         SEW_8,  MODE_UNIT,    32'h0000_3001, 32'd0,  9, 2};
    rows[3] = '{"strided_sew16",     SEW_16, MODE_STRIDED, 32'h0000_4003, 32'd7,  5, 1};
    rows[4] = '{"strided_sew8",      SEW_8,  MODE_STRIDED, 32'h0000_5002, 32'd13, 7, 0};
    rows[5] = '{"backpressure",      SEW_32, MODE_STRIDED, 32'h0000_6001, 32'd5,  8, 12};
    rows[6] = '{"restart_sew32",     SEW_32, MODE_UNIT,    32'h0000_7000, 32'd0,  3, 0};
  endtask

  task automatic run_row(row_t row);
    int          b;
    logic [31:0] elem;
    cur_name  = row.name;
    cur_delay = row.delay;
    cfg_i.sew       = row.sew;
    cfg_i.mode      = row.mode;
    cfg_i.base_addr = row.base;
    cfg_i.stride    = row.stride;
    cfg_i.batches   = 8'(row.batches);
    cfg_load_i = 1'b1;
    @(posedge clk);
    #2;
    cfg_load_i = 1'b0;
    check_value("done after load", 32'd0, 32'(done_o));
    check_value("fill_ready after load", 32'd1, 32'(fill_ready_o));
    b = 0;
    while (b < row.batches) begin
      if (fill_ready_o) begin
        lane_valid_i = 1'b1;
        for (int l = 0; l < LANES; l++) begin
          elem = $urandom();
          lane_elem_i[l] = elem;
          exp_q.push_back(expected_beat(row, b * LANES + l, elem));
        end
        b++;
      end else begin
        lane_valid_i = 1'b0;
      end
      @(posedge clk);
      #2;
    end
    lane_valid_i = 1'b0;
    while (!done_o) begin
      @(posedge clk);
      #2;
    end
    check_value("beats missing at done", 32'd0, 32'(exp_q.size()));
    // Let every credit go back before the next transfer
    while (due_q.size() != 0 || credit_return_i) begin
      @(posedge clk);
      #2;
    end
  endtask

  //////////////////////////////////////////////////////////////
  // Scoreboard, sampled at the falling edge
  //////////////////////////////////////////////////////////////
  initial begin
    beat_t exp_beat;
    forever begin
      @(negedge clk);
      ncycle++;
      if (rstn && beat_valid_o) begin
        if (exp_q.size() == 0) begin
          errors++;
          $display("%s: a beat for address %h arrived when none was expected",
                   cur_name, beat_o.addr);
        end else begin
          exp_beat = exp_q.pop_front();
          check_value("addr", exp_beat.addr, beat_o.addr);
          check_value("data", exp_beat.data, beat_o.data);
          check_value("strobe", 32'(exp_beat.strobe), 32'(beat_o.strobe));
        end
        unreturned++;
        check_value("unreturned beats within credits", 32'd1, 32'(unreturned <= CREDITS));
        due_q.push_back(ncycle + cur_delay);
      end
    end
  end

  // Credit return, one pulse per due beat
  initial begin
    credit_return_i = 1'b0;
    forever begin
      @(posedge clk);
      #2;
      if (due_q.size() != 0 && due_q[0] <= ncycle) begin
        void'(due_q.pop_front());
        unreturned--;
        credit_return_i = 1'b1;
      end else begin
        credit_return_i = 1'b0;
      end
    end
  end

  initial begin
    longint limit_cycles;
    #1;
    limit_cycles = 16;
    foreach (rows[r])
      limit_cycles += (rows[r].batches * LANES + rows[r].batches + 20) * (rows[r].delay + 2);
    #(limit_cycles * 40);
    $display("timeout: the transfers did not finish within %0d cycles", limit_cycles);
    $display("SOME TESTS FAILED");
    $finish;
  end

  initial begin
    int total;
    void'($urandom(77));
    rstn         = 1'b0;
    cfg_load_i   = 1'b0;
    cfg_i        = '0;
    lane_valid_i = 1'b0;
    lane_elem_i  = '0;
    load_table();
    repeat (16) @(posedge clk);
    #2;
    rstn = 1'b1;
    check_value("fill_ready after reset", 32'd0, 32'(fill_ready_o));
    check_value("beat_valid after reset", 32'd0, 32'(beat_valid_o));
    check_value("done after reset", 32'd0, 32'(done_o));
    for (int r = 0; r < NROWS; r++)
      run_row(rows[r]);
    total = errors + int'(store_unit_i.sequencer_i.props_i.fails);
    $display("%0d check errors, %0d assertion failures, %0d checks", errors,
             store_unit_i.sequencer_i.props_i.fails, checks);
    if (total == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule : tb_store_unit

// ==== store_unit_properties.sv ====
// Sequencer assertions
// Credit bound, requests against credits, fill and done exclusive
`timescale 1ns/1ps

module store_unit_properties #(
  parameter int CREDITS = 4,
  parameter int CRED_W  = 3
) (
  input logic              clk,
  input logic              rstn,
  input logic [CRED_W-1:0] credit_i,
  input logic              req_valid_i,
  input logic              fill_ready_i,
  input logic              done_i
);

  int unsigned fails = 0;  // Failed assertions so far

  credit_limit: assert property (@(posedge clk) disable iff (!rstn)
    credit_i <= CRED_W'(CREDITS))
    else begin
      fails++;
      $error("credit count above the configured number of credits");
    end

  // A request needs a credit in the cycle it was issued
  req_has_credit: assert property (@(posedge clk) disable iff (!rstn)
    req_valid_i |-> $past(credit_i) != '0)
    else begin
      fails++;
      $error("read request issued with zero credits");
    end

  fill_done_excl: assert property (@(posedge clk) disable iff (!rstn)
    !(fill_ready_i && done_i))
    else begin
      fails++;
      $error("fill_ready and done high together");
    end

endmodule : store_unit_properties

// ==== store_unit_top.sv ====
// Store unit top level
// Sequencer, lane packer, one bank per lane and the element extractor
`timescale 1ns/1ps

module store_unit_top
  import vec_cfg_pkg::*;
  import store_bus_pkg::*;
#(
  parameter int LANES   = 4,
  parameter int DEPTH   = 16,
  parameter int CREDITS = 4
) (
  input  logic                   clk,
  input  logic                   rstn,
  input  logic                   cfg_load_i,
  input  store_cfg_t             cfg_i,
  input  logic                   lane_valid_i,
  input  logic [LANES-1:0][31:0] lane_elem_i,
  input  logic                   credit_return_i,
  output logic                   fill_ready_o,
  output logic                   beat_valid_o,
  output beat_t                  beat_o,
  output logic                   done_o
);

  logic [7:0]             wr_batch;
  logic                   wr_stb;
  rd_req_t                rd_req;
  logic                   bank_we;
  logic [BANK_ADDR_W-1:0] bank_waddr;
  logic [3:0]             bank_be;
  elem_word_u [LANES-1:0] bank_wdata;
  elem_word_u [LANES-1:0] bank_rdata;

  store_sequencer #(
    .LANES   (LANES),
    .DEPTH   (DEPTH),
    .CREDITS (CREDITS)
  ) sequencer_i (
    .clk             (clk),
    .rstn            (rstn),
    .cfg_load_i      (cfg_load_i),
    .cfg_i           (cfg_i),
    .lane_valid_i    (lane_valid_i),
    .credit_return_i (credit_return_i),
    .fill_ready_o    (fill_ready_o),
    .wr_batch_o      (wr_batch),
    .wr_stb_o        (wr_stb),
    .rd_req_o        (rd_req),
    .done_o          (done_o)
  );

  // Element width of the running transfer rides on the request bus
  lane_pack #(.LANES(LANES)) pack_i (
    .clk          (clk),
    .rstn         (rstn),
    .wr_stb_i     (wr_stb),
    .wr_batch_i   (wr_batch),
    .sew_i        (rd_req.sew),
    .lane_elem_i  (lane_elem_i),
    .bank_we_o    (bank_we),
    .bank_waddr_o (bank_waddr),
    .bank_be_o    (bank_be),
    .bank_wdata_o (bank_wdata)
  );

  for (genvar l = 0; l < LANES; l++) begin : g_bank
    lane_bank #(.DEPTH(DEPTH)) bank_i (
      .clk     (clk),
      .we_i    (bank_we),
      .waddr_i (bank_waddr),
      .be_i    (bank_be),
      .wdata_i (bank_wdata[l]),
      .raddr_i (rd_req.word_addr),
      .rdata_o (bank_rdata[l])
    );
  end

  elem_extract #(.LANES(LANES)) extract_i (
    .clk          (clk),
    .rstn         (rstn),
    .rd_req_i     (rd_req),
    .bank_rdata_i (bank_rdata),
    .beat_valid_o (beat_valid_o),
    .beat_o       (beat_o)
  );

endmodule : store_unit_top

// ==== elem_extract.sv ====
// Element extractor
// Lane select, slot decode with zero extension, data and strobe rotation,
// registered output beat
`timescale 1ns/1ps

module elem_extract
  import vec_cfg_pkg::*;
  import store_bus_pkg::*;
#(
  parameter int LANES = 4
) (
  input  logic                   clk,
  input  logic                   rstn,
  input  rd_req_t                rd_req_i,
  input  elem_word_u [LANES-1:0] bank_rdata_i,
  output logic                   beat_valid_o,
  output beat_t                  beat_o
);

  rd_req_t     req_q;     // Aligned with the bank read data
  elem_word_u  word;
  logic [31:0] elem;
  logic [3:0]  mask;
  logic [1:0]  offs;
  logic [63:0] data_dbl;
  logic [7:0]  strb_dbl;

  always_ff @(posedge clk) begin
    req_q <= rd_req_i;
    if (!rstn)
      req_q.valid <= 1'b0;
  end

  assign word = bank_rdata_i[req_q.lane];
  assign offs = req_q.addr[1:0];

  ////////////////////////////////////////////////////////////
  // Slot decode and rotation to byte lane
  ////////////////////////////////////////////////////////////
  always_comb begin
    case (req_q.sew)
      SEW_8: begin
        elem = {24'h0, word.b[req_q.slot]};
        mask = 4'b0001;
      end
      SEW_16: begin
        elem = {16'h0, word.h[req_q.slot[0]]};
        mask = 4'b0011;
      end
      default: begin
        elem = word.w;
        mask = 4'b1111;
      end
    endcase
    data_dbl = {elem, elem} << {offs, 3'b000};  // Upper half is the rotate left
    strb_dbl = {mask, mask} << offs;
  end

  always_ff @(posedge clk) begin
    if (!rstn) beat_valid_o <= 1'b0;
    else       beat_valid_o <= req_q.valid;
  end

  always_ff @(posedge clk) begin
    beat_o.addr   <= {req_q.addr[31:2], 2'b00};
    beat_o.data   <= data_dbl[63:32];
    beat_o.strobe <= strb_dbl[7:4];
  end

endmodule : elem_extract

// ==== lane_bank.sv ====
// Lane bank
// Simple dual-port RAM, byte write enables, one-cycle registered read
`timescale 1ns/1ps

module lane_bank
  import store_bus_pkg::*;
#(
  parameter int DEPTH = 16
) (
  input  logic                   clk,
  input  logic                   we_i,
  input  logic [BANK_ADDR_W-1:0] waddr_i,
  input  logic [3:0]             be_i,
  input  elem_word_u             wdata_i,
  input  logic [BANK_ADDR_W-1:0] raddr_i,
  output elem_word_u             rdata_o
);

  localparam int AW = $clog2(DEPTH);

  elem_word_u mem [DEPTH];

  always_ff @(posedge clk) begin
    if (we_i) begin
      for (int i = 0; i < 4; i++) begin
        if (be_i[i])
          mem[waddr_i[AW-1:0]].b[i] <= wdata_i.b[i];  // Byte column write
      end
    end
    rdata_o <= mem[raddr_i[AW-1:0]];
  end

endmodule : lane_bank

// ==== lane_pack.sv ====
// Lane packer
// Places each lane element in its slot and registers the bank write
`timescale 1ns/1ps

module lane_pack
  import vec_cfg_pkg::*;
  import store_bus_pkg::*;
#(
  parameter int LANES = 4
) (
  input  logic                         clk,
  input  logic                         rstn,
  input  logic                         wr_stb_i,
  input  logic [7:0]                   wr_batch_i,
  input  sew_e                         sew_i,
  input  logic [LANES-1:0][31:0]       lane_elem_i,
  output logic                         bank_we_o,
  output logic [BANK_ADDR_W-1:0]       bank_waddr_o,
  output logic [3:0]                   bank_be_o,
  output elem_word_u [LANES-1:0]       bank_wdata_o
);

  logic [BANK_ADDR_W-1:0] waddr;
  logic [1:0]             slot;
  logic [3:0]             be;
  elem_word_u [LANES-1:0] wdata;

  // Batch index to word and slot
  always_comb begin
    waddr = BANK_ADDR_W'(wr_batch_i >> (2'd2 - sew_i));  // Divide by slots per word
    case (sew_i)
      SEW_8: begin
        slot = wr_batch_i[1:0];
        be   = 4'b0001 << slot;
      end
      SEW_16: begin
        slot = {1'b0, wr_batch_i[0]};
        be   = 4'b0011 << {slot[0], 1'b0};
      end
      default: begin
        slot = 2'b00;
        be   = 4'b1111;
      end
    endcase
  end

  always_comb begin
    for (int l = 0; l < LANES; l++) begin
      wdata[l].w = '0;
      case (sew_i)
        SEW_8:   wdata[l].b[slot]    = lane_elem_i[l][7:0];
        SEW_16:  wdata[l].h[slot[0]] = lane_elem_i[l][15:0];
        default: wdata[l].w          = lane_elem_i[l];
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (!rstn) bank_we_o <= 1'b0;
    else       bank_we_o <= wr_stb_i;
  end

  always_ff @(posedge clk) begin
    if (wr_stb_i) begin
      bank_waddr_o <= waddr;
      bank_be_o    <= be;
      bank_wdata_o <= wdata;
    end
  end

endmodule : lane_pack

// ==== store_sequencer.sv ====
// Store sequencer
// Config latch, batch and element counters, address generator, credit counter
`timescale 1ns/1ps

module store_sequencer
  import vec_cfg_pkg::*;
  import store_bus_pkg::*;
#(
  parameter int LANES   = 4,
  parameter int DEPTH   = 16,
  parameter int CREDITS = 4
) (
  input  logic       clk,
  input  logic       rstn,
  input  logic       cfg_load_i,
  input  store_cfg_t cfg_i,
  input  logic       lane_valid_i,
  input  logic       credit_return_i,
  output logic       fill_ready_o,
  output logic [7:0] wr_batch_o,
  output logic       wr_stb_o,
  output rd_req_t    rd_req_o,
  output logic       done_o
);

  localparam int LOG_LANES = $clog2(LANES);
  localparam int ELEM_W    = 8 + $clog2(MAX_LANES);
  localparam int CRED_W    = $clog2(CREDITS + 1);
  localparam int DEPTH_W   = $clog2(DEPTH);

  typedef enum logic [1:0] {S_IDLE, S_FILL, S_ISSUE, S_DONE} seq_state_e;

  seq_state_e        state_q;
  store_cfg_t        cfg_q;
  logic [7:0]        batch_q;     // Accepted batches
  logic [ELEM_W-1:0] issue_q;     // Next element to read
  logic [ELEM_W-1:0] beat_q;      // Beats already out
  logic [ELEM_W-1:0] elem_total;
  logic [CRED_W-1:0] credit_q;
  logic [1:0]        inflight_q;  // Request valid delayed to the beat cycle
  logic [31:0]       addr_q;
  logic [31:0]       step;
  logic [7:0]        elem_batch;
  logic [7:0]        word_idx;
  logic [1:0]        slot_mask;
  logic              accept;
  logic              issue;
  rd_req_t           req_q;

  assign fill_ready_o = (state_q == S_FILL);
  assign done_o       = (state_q == S_DONE);
  assign accept       = fill_ready_o & lane_valid_i;
  assign wr_stb_o     = accept;
  assign wr_batch_o   = batch_q;
  assign rd_req_o     = req_q;

  assign elem_total = ELEM_W'(cfg_q.batches) << LOG_LANES;
  assign issue = (state_q == S_ISSUE) && (issue_q != elem_total) && (credit_q != '0);

  ////////////////////////////////////////////////////////////
  // Element to lane, word and slot
  ////////////////////////////////////////////////////////////
  assign step       = (cfg_q.mode == MODE_STRIDED) ? cfg_q.stride : (32'd1 << cfg_q.sew);
  assign elem_batch = 8'(issue_q >> LOG_LANES);
  assign word_idx   = elem_batch >> (2'd2 - cfg_q.sew);  // Divide by slots per word

  always_comb begin
    case (cfg_q.sew)
      SEW_8:   slot_mask = 2'b11;  // Four slots per word
      SEW_16:  slot_mask = 2'b01;
      default: slot_mask = 2'b00;
    endcase
  end

  ////////////////////////////////////////////////////////////
  // Transfer control
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (!rstn) begin
      state_q <= S_IDLE;
      cfg_q   <= '0;
      batch_q <= '0;
      issue_q <= '0;
      beat_q  <= '0;
      addr_q  <= '0;
    end else if (cfg_load_i) begin
      state_q <= S_FILL;
      cfg_q   <= cfg_i;
      batch_q <= '0;
      issue_q <= '0;
      beat_q  <= '0;
    end else begin
      case (state_q)
        S_FILL: begin
          if (accept) begin
            batch_q <= batch_q + 8'd1;
            if (batch_q == cfg_q.batches - 8'd1) begin
              state_q <= S_ISSUE;            // Next cycle is the guard cycle
              addr_q  <= cfg_q.base_addr;
            end
          end
        end
        S_ISSUE: begin
          if (issue) begin
            issue_q <= issue_q + ELEM_W'(1);
            addr_q  <= addr_q + step;
          end
          if (inflight_q[1]) begin
            beat_q <= beat_q + ELEM_W'(1);
            if (beat_q == elem_total - ELEM_W'(1))
              state_q <= S_DONE;           // Last beat leaves this cycle
          end
        end
        default: ;
      endcase
    end
  end

  // Credits and in-flight tracking
  always_ff @(posedge clk) begin
    if (!rstn) begin
      credit_q   <= CRED_W'(CREDITS);
      inflight_q <= '0;
    end else begin
      credit_q   <= credit_q + CRED_W'(credit_return_i) - CRED_W'(issue);
      inflight_q <= {inflight_q[0], req_q.valid};
    end
  end

  // Read request with the element width of the loaded config
  always_ff @(posedge clk) begin
    if (!rstn) begin
      req_q.valid <= 1'b0;
      req_q.sew   <= SEW_8;
    end else begin
      req_q.valid <= issue;
      if (cfg_load_i)
        req_q.sew <= cfg_i.sew;
    end
    if (issue) begin
      req_q.lane      <= 4'(issue_q & ELEM_W'(LANES - 1));
      req_q.word_addr <= BANK_ADDR_W'(word_idx[DEPTH_W-1:0]);
      req_q.slot      <= elem_batch[1:0] & slot_mask;
      req_q.addr      <= addr_q;
    end
  end

endmodule : store_sequencer

// ==== store_bus_pkg.sv ====
// Store datapath types
// Bank word union, read request and output beat, plus size limits

package store_bus_pkg;
  import vec_cfg_pkg::*;

  localparam int MAX_LANES   = 16;  // Upper limit for LANES
  localparam int BANK_ADDR_W = 8;   // Bank word address, DEPTH up to 256

  // A bank word seen as bytes, halfwords or a full word
  typedef union packed {
    logic [3:0][7:0]  b;
    logic [1:0][15:0] h;
    logic [31:0]      w;
  } elem_word_u;

  // One element read, issued by the sequencer
  typedef struct packed {
    logic                   valid;
    logic [3:0]             lane;
    logic [BANK_ADDR_W-1:0] word_addr;
    logic [1:0]             slot;       // Byte or halfword slot in the word
    sew_e                   sew;
    logic [31:0]            addr;       // Full byte address of the element
  } rd_req_t;

  // Memory beat at the output
  typedef struct packed {
    logic [31:0] addr;    // Word aligned
    logic [31:0] data;
    logic [3:0]  strobe;
  } beat_t;

endpackage : store_bus_pkg

// ==== vec_cfg_pkg.sv ====
// Store configuration types
// Element width, addressing mode and the latched transfer setup

package vec_cfg_pkg;

  // Element width, coded as log2 of the element bytes
  typedef enum logic [1:0] {
    SEW_8  = 2'd0,
    SEW_16 = 2'd1,
    SEW_32 = 2'd2
  } sew_e;

  typedef enum logic {
    MODE_UNIT    = 1'b0,  // Step is the element size
    MODE_STRIDED = 1'b1   // Step is the stride field
  } stride_mode_e;

  // One store transfer as given by the control side
  typedef struct packed {
    sew_e         sew;
    stride_mode_e mode;
    logic [31:0]  base_addr;
    logic [31:0]  stride;     // Byte stride, strided mode only
    logic [7:0]   batches;    // Lane writes per transfer
  } store_cfg_t;

endpackage : vec_cfg_pkg
